/* cpu16.f */
cpu16_pkg.sv
cpu16_alu.sv
cpu16_regs.sv
cpu16_ramctl.sv
cpu16_ctrl.sv
cpu16.sv
cpu16_check.sv
cpu16_tb.sv

/* cpu16.sv */
/*
 * Core top level with the RAM port and register dump port
 * Controller, register file, ALU and memory controller
 */
`timescale 1ns/10ps

module cpu16
    import cpu16_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,

    output logic [addr_w-1:0] ram_addr,
    input  logic [data_w-1:0] ram_dout,
    output logic [data_w-1:0] ram_din,
    output logic              ram_we,
    // Register dump
    input  logic [idx_w-1:0]  dmp_addr,
    output logic [data_w-1:0] dmp_dout,

    output logic              halted
);

ctrl_t             ctl;
logic [addr_w-1:0] pc;
logic [idx_w-1:0]  rs_idx, rd_idx;
logic [data_w-1:0] imm, rs_val, rd_val;
logic [data_w-1:0] alu_out, rdata;
logic              z, c;

cpu16_ctrl u_ctrl(
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .cen        ( cen       ),
    .rdata      ( rdata     ),
    .z          ( z         ),
    .c          ( c         ),
    .ctl        ( ctl       ),
    .pc         ( pc        ),
    .rs_idx     ( rs_idx    ),
    .rd_idx     ( rd_idx    ),
    .imm        ( imm       ),
    .halted     ( halted    )
);

cpu16_regs u_regs(
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .cen        ( cen       ),
    .ctl        ( ctl       ),
    .rs_idx     ( rs_idx    ),
    .rd_idx     ( rd_idx    ),
    .alu_out    ( alu_out   ),
    .imm        ( imm       ),
    .rdata      ( rdata     ),
    .dmp_addr   ( dmp_addr  ),
    .rs_val     ( rs_val    ),
    .rd_val     ( rd_val    ),
    .dmp_dout   ( dmp_dout  )
);

// Destination register is the left operand
cpu16_alu u_alu(
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .cen        ( cen       ),
    .ctl        ( ctl       ),
    .a          ( rd_val    ),
    .b          ( rs_val    ),
    .result     ( alu_out   ),
    .z          ( z         ),
    .c          ( c         )
);

cpu16_ramctl u_ramctl(
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .cen        ( cen       ),
    .ctl        ( ctl       ),
    .pc         ( pc        ),
    .rs_val     ( rs_val    ),
    .rd_val     ( rd_val    ),
    .ram_dout   ( ram_dout  ),
    .ram_addr   ( ram_addr  ),
    .ram_din    ( ram_din   ),
    .ram_we     ( ram_we    ),
    .rdata      ( rdata     )
);

endmodule

/* cpu16_alu.sv */
/*
 * Combinational add, subtract and logic operations
 * Registered zero and carry flags
 */
`timescale 1ns/10ps

module cpu16_alu
    import cpu16_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    input  ctrl_t             ctl,
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    output logic [data_w-1:0] result,
    output logic              z,
    output logic              c
);

// One extra bit on top holds carry or borrow
logic [data_w:0] wide;

always_comb begin
    case (ctl.alu_op)
        alu_add: wide = {1'b0, a} + {1'b0, b};
        alu_sub: wide = {1'b0, a} - {1'b0, b};
        alu_and: wide = {1'b0, a & b};
        alu_or:  wide = {1'b0, a | b};
        alu_xor: wide = {1'b0, a ^ b};
        default: wide = {1'b0, b};
    endcase
end

assign result = wide[data_w-1:0];

// Logic operations clear C since the top bit is zero
always_ff @(posedge clk) begin
    if (!rst_n) begin
        z <= 1'b0;
        c <= 1'b0;
    end else if (cen && ctl.flag_we) begin
        z <= result == '0;
        c <= wide[data_w];
    end
end

endmodule

/* cpu16_check.sv */
/*
 * Checker for the cpu16 testbench
 * Expected store and register tables, filled by the testbench top
 * Store and register dump comparison with error counters
 */
`timescale 1ns/10ps

module cpu16_check
    import cpu16_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    input  logic              ram_we,
    input  logic [addr_w-1:0] ram_addr,
    input  logic [data_w-1:0] ram_din,
    input  logic              dmp_valid,
    input  logic [idx_w-1:0]  dmp_addr,
    input  logic [data_w-1:0] dmp_dout,
    input  logic              run_done,
    output int                store_errs,
    output int                reg_errs
);

logic [addr_w-1:0] exp_addr [64];
logic [data_w-1:0] exp_data [64];
logic [data_w-1:0] exp_reg  [reg_n];
int                n_exp     = 0;
int                st_idx    = 0;
int                n_st_err  = 0;
int                n_reg_err = 0;

assign store_errs = n_st_err;
assign reg_errs   = n_reg_err;

task automatic expect_store(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    if (n_exp < $size(exp_addr)) begin
        exp_addr[n_exp] = addr;
        exp_data[n_exp] = data;
        n_exp++;
    end else begin
        $display("stores: expected store table is full, entry for %h dropped", addr);
        n_st_err++;
    end
endtask

task automatic expect_reg(input logic [idx_w-1:0] idx, input logic [data_w-1:0] value);
    exp_reg[idx] = value;
endtask

// Store index restarts with every reset of the core
always @(posedge clk) begin
    if (!rst_n) begin
        st_idx <= 0;
    end else begin
        if (cen && ram_we) begin
            if (st_idx >= n_exp) begin
                $display("stores: unexpected extra store of %h to address %h", ram_din, ram_addr);
                n_st_err++;
            end else if (ram_addr !== exp_addr[st_idx] || ram_din !== exp_data[st_idx]) begin
                $display("mismatch stores #%0d: expected %h at %h, actual %h at %h", st_idx,
                         exp_data[st_idx], exp_addr[st_idx], ram_din, ram_addr);
                n_st_err++;
            end
            st_idx <= st_idx + 1;
        end
        if (dmp_valid && dmp_dout !== exp_reg[dmp_addr]) begin
            $display("mismatch regs r%0d: expected %h, actual %h", dmp_addr,
                     exp_reg[dmp_addr], dmp_dout);
            n_reg_err++;
        end
        if (run_done && st_idx != n_exp) begin
            $display("stores: core made %0d stores but %0d were expected", st_idx, n_exp);
            n_st_err++;
        end
    end
end

endmodule

/* cpu16_ctrl.sv */
/*
 * Instruction sequencer: fetch, decode, exec and mem states
 * Program counter with relative jumps on the Z flag
 * Opcode to datapath command decoding
 */
`timescale 1ns/10ps

module cpu16_ctrl
    import cpu16_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    input  logic [data_w-1:0] rdata,
    input  logic              z,
    input  logic              c,
    output ctrl_t             ctl,
    output logic [addr_w-1:0] pc,
    output logic [idx_w-1:0]  rs_idx,
    output logic [idx_w-1:0]  rd_idx,
    output logic [data_w-1:0] imm,
    output logic              halted
);

state_t            state;
instr_t            ir;
instr_t            cur;
logic              ld_pend;
logic              taken;
logic              is_halt;
logic [addr_w-1:0] pc_inc;
logic [addr_w-1:0] pc_jmp;

// Word read at pc reaches rdata in exec, ir keeps it afterwards
assign cur = (state == s_exec) ? instr_t'(rdata) : ir;

assign rs_idx = cur.r.rs;
assign rd_idx = cur.r.rd;
assign imm    = {{(data_w-imm_w){cur.i.imm[imm_w-1]}}, cur.i.imm};
assign halted = state == s_halted;

// Both jumps in this set test Z
assign taken = (cur.r.op == op_jrz  &&  z) ||
               (cur.r.op == op_jrnz && !z);

assign pc_inc = pc + addr_w'(1);
assign pc_jmp = pc_inc + {{(addr_w-imm_w){cur.i.imm[imm_w-1]}}, cur.i.imm};

always_comb begin
    ctl          = '0;
    ctl.wr_sel   = wr_alu;
    ctl.addr_sel = addr_pc;
    is_halt      = 1'b0;

    case (cur.r.op)
        op_add:  ctl.alu_op = alu_add;
        op_sub:  ctl.alu_op = alu_sub;
        op_and:  ctl.alu_op = alu_and;
        op_or:   ctl.alu_op = alu_or;
        op_xor:  ctl.alu_op = alu_xor;
        default: ctl.alu_op = alu_pass;
    endcase

    case (state)
        s_fetch: begin
            // Load data from the previous instruction is on rdata now
            if (ld_pend) begin
                ctl.reg_we = 1'b1;
                ctl.wr_sel = wr_mem;
            end
        end
        s_exec: begin
            case (cur.r.op)
                op_ldi: begin
                    ctl.reg_we = 1'b1;
                    ctl.wr_sel = wr_imm;
                end
                op_add, op_sub, op_and, op_or, op_xor: begin
                    ctl.reg_we  = 1'b1;
                    ctl.flag_we = 1'b1;
                end
                op_ld: begin
                    ctl.mem_rd   = 1'b1;
                    ctl.addr_sel = addr_reg;
                end
                op_st: begin
                    ctl.mem_wr   = 1'b1;
                    ctl.addr_sel = addr_reg;
                end
                op_jrz, op_jrnz: ;  // pc update only
                default: is_halt = 1'b1;
            endcase
        end
        default: ;
    endcase
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state   <= s_fetch;
        pc      <= '0;
        ld_pend <= 1'b0;
    end else if (cen) begin
        case (state)
            s_fetch: begin
                state   <= s_decode;
                ld_pend <= 1'b0;
            end
            s_decode: state <= s_exec;
            s_exec: begin
                ld_pend <= ctl.mem_rd;
                if (is_halt) begin
                    state <= s_halted;
                end else begin
                    state <= (ctl.mem_rd || ctl.mem_wr) ? s_mem : s_fetch;
                    pc    <= taken ? pc_jmp : pc_inc;
                end
            end
            s_mem:   state <= s_fetch;
            default: state <= s_halted;
        endcase
    end
end

// Instruction held for the mem cycle and the load write-back
always_ff @(posedge clk) begin
    if (cen && state == s_exec) begin
        ir <= cur;
    end
end

endmodule

/* cpu16_input.dat */
# P <word>: program word, loaded from address 0 upward; text after it is ignored
# W <addr> <data>: expected store in order; R <reg> <value>: final register value
P 12fd  ldi  r1, -3
P 1464  ldi  r2, 100
P 2440  add  r2, r1
P 165a  ldi  r3, 0x5a
P 4680  and  r3, r2
P 5640  or   r3, r1
P 6680  xor  r3, r2
P 3440  sub  r2, r1
P 1840  ldi  r4, 0x40
P 8700  st   r3, [r4]
P 1a41  ldi  r5, 0x41
P 8540  st   r2, [r5]
P 7d00  ld   r6, [r4]
P 1e03  ldi  r7, 3
P 1001  ldi  r0, 1
P 2bc0  add  r5, r7     loop start
P 3e00  sub  r7, r0
P a0fd  jrnz -3
P 9001  jrz  +1         taken
P 1a7f  ldi  r5, 0x7f   skipped
P 8b00  st   r5, [r4]
P a001  jrnz +1         not taken
P 1822  ldi  r4, 0x22
P f000  halt
W 0040 ff9c
W 0041 0064
W 0040 0047
R 0 0001
R 1 fffd
R 2 0064
R 3 ff9c
R 4 0022
R 5 0047
R 6 ff9c
R 7 0000

/* cpu16_pkg.sv */
/*
 * Shared sizes, opcode encoding and instruction word layouts
 * Datapath command bundle and controller state type
 */
package cpu16_pkg;

    localparam int data_w = 16;
    localparam int addr_w = 16;
    localparam int reg_n  = 8;
    localparam int idx_w  = $clog2(reg_n);
    localparam int imm_w  = 8;

    // Codes 0 and b..e are not assigned and act as halt
    typedef enum logic [3:0] {
        op_ldi  = 4'h1,
        op_add  = 4'h2,
        op_sub  = 4'h3,
        op_and  = 4'h4,
        op_or   = 4'h5,
        op_xor  = 4'h6,
        op_ld   = 4'h7,
        op_st   = 4'h8,
        op_jrz  = 4'h9,
        op_jrnz = 4'ha,
        op_halt = 4'hf
    } opcode_t;

    // Register format: rd <= rd op rs, or memory through rs
    typedef struct packed {
        opcode_t          op;
        logic [idx_w-1:0] rd;
        logic [idx_w-1:0] rs;
        logic [5:0]       spare;
    } instr_r_t;

    // Immediate format: load immediate and relative jumps
    typedef struct packed {
        opcode_t                 op;
        logic [idx_w-1:0]        rd;
        logic                    spare;
        logic signed [imm_w-1:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    typedef enum logic [2:0] {
        alu_pass = 3'd0,
        alu_add  = 3'd1,
        alu_sub  = 3'd2,
        alu_and  = 3'd3,
        alu_or   = 3'd4,
        alu_xor  = 3'd5
    } alu_op_t;

    typedef enum logic [1:0] {wr_alu, wr_imm, wr_mem} wr_sel_t;

    typedef enum logic {addr_pc, addr_reg} addr_sel_t;

    typedef struct packed {
        logic      reg_we;
        wr_sel_t   wr_sel;
        alu_op_t   alu_op;
        logic      flag_we;
        logic      mem_rd;
        logic      mem_wr;
        addr_sel_t addr_sel;
    } ctrl_t;

    typedef enum logic [2:0] {s_fetch, s_decode, s_exec, s_mem, s_halted} state_t;

endpackage

/* cpu16_ramctl.sv */
/*
 * RAM address and write data selection
 * Read data register, one cycle behind ram_dout
 */
`timescale 1ns/10ps

module cpu16_ramctl
    import cpu16_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    input  ctrl_t             ctl,
    input  logic [addr_w-1:0] pc,
    input  logic [data_w-1:0] rs_val,
    input  logic [data_w-1:0] rd_val,
    input  logic [data_w-1:0] ram_dout,
    output logic [addr_w-1:0] ram_addr,
    output logic [data_w-1:0] ram_din,
    output logic              ram_we,
    output logic [data_w-1:0] rdata
);

// Loads and stores go through the source register
assign ram_addr = (ctl.addr_sel == addr_reg) ? addr_w'(rs_val) : pc;

// Store data always comes from the destination register
assign ram_din = rd_val;
assign ram_we  = ctl.mem_wr;

// Instruction words and load data both pass through here
always_ff @(posedge clk) begin
    if (!rst_n) begin
        rdata <= '0;
    end else if (cen) begin
        rdata <= ram_dout;
    end
end

endmodule

/* cpu16_regs.sv */
/*
 * Eight general registers, two read ports and one write port
 * Write source select and register dump read port
 */
`timescale 1ns/10ps

module cpu16_regs
    import cpu16_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    input  ctrl_t             ctl,
    input  logic [idx_w-1:0]  rs_idx,
    input  logic [idx_w-1:0]  rd_idx,
    input  logic [data_w-1:0] alu_out,
    input  logic [data_w-1:0] imm,
    input  logic [data_w-1:0] rdata,
    input  logic [idx_w-1:0]  dmp_addr,
    output logic [data_w-1:0] rs_val,
    output logic [data_w-1:0] rd_val,
    output logic [data_w-1:0] dmp_dout
);

logic [data_w-1:0] regs [reg_n];
logic [data_w-1:0] wr_data;

always_comb begin
    case (ctl.wr_sel)
        wr_imm:  wr_data = imm;
        wr_mem:  wr_data = rdata;
        default: wr_data = alu_out;
    endcase
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        regs <= '{default: '0};
    end else if (cen && ctl.reg_we) begin
        regs[rd_idx] <= wr_data;
    end
end

assign rs_val = regs[rs_idx];
assign rd_val = regs[rd_idx];

// Dump port has its own index, the core never sees it
assign dmp_dout = regs[dmp_addr];

endmodule

/* cpu16_tb.sv */
/*
 * Testbench top for the cpu16 core
 * Clock, reset, 256-word RAM model and program loading from the input file
 * Two runs of one program, the second with a random clock enable
 */
`timescale 1ns/10ps

module cpu16_tb
    import cpu16_pkg::*;
();

logic              clk;
logic              rst_n;
logic              cen;
logic [addr_w-1:0] ram_addr;
logic [data_w-1:0] ram_dout;
logic [data_w-1:0] ram_din;
logic              ram_we;
logic [idx_w-1:0]  dmp_addr;
logic [data_w-1:0] dmp_dout;
logic              halted;
logic              dmp_valid;
logic              run_done;
logic [data_w-1:0] ram  [256];
logic [data_w-1:0] prog [256];
int                n_prog     = 0;
int                seed       = 32'h447a_441b;
int                setup_errs = 0;
int                timeouts   = 0;
int                store_errs;
int                reg_errs;

cpu16 dut0(
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .cen        ( cen       ),
    .ram_addr   ( ram_addr  ),
    .ram_dout   ( ram_dout  ),
    .ram_din    ( ram_din   ),
    .ram_we     ( ram_we    ),
    .dmp_addr   ( dmp_addr  ),
    .dmp_dout   ( dmp_dout  ),
    .halted     ( halted    )
);

cpu16_check check0(
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .cen        ( cen        ),
    .ram_we     ( ram_we     ),
    .ram_addr   ( ram_addr   ),
    .ram_din    ( ram_din    ),
    .dmp_valid  ( dmp_valid  ),
    .dmp_addr   ( dmp_addr   ),
    .dmp_dout   ( dmp_dout   ),
    .run_done   ( run_done   ),
    .store_errs ( store_errs ),
    .reg_errs   ( reg_errs   )
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

// Read data shows up one enabled edge after the address
always @(posedge clk) begin
    if (cen) begin
        if (ram_we) begin
            ram[ram_addr[7:0]] <= ram_din;
        end
        ram_dout <= ram[ram_addr[7:0]];
    end
end

task automatic read_input();
    int               fd;
    int               n;
    logic [7:0]       kind;
    logic [15:0]      v0;
    logic [15:0]      v1;
    logic [8*120-1:0] rest;
    fd = $fopen("cpu16_input.dat", "r");
    if (fd == 0) begin
        $display("cannot open cpu16_input.dat for reading");
        setup_errs++;
        return;
    end
    while ($fscanf(fd, " %c", kind) == 1) begin
        case (kind)
            "P": begin
                n = $fscanf(fd, "%h", v0);
                prog[n_prog] = v0;
                n_prog++;
            end
            "W": begin
                n = $fscanf(fd, "%h %h", v0, v1);
                check0.expect_store(v0, v1);
            end
            "R": begin
                n = $fscanf(fd, "%h %h", v0, v1);
                check0.expect_reg(v0[idx_w-1:0], v1);
            end
            default: n = 1;
        endcase
        if (n < 1) begin
            $display("malformed %c line in cpu16_input.dat", kind);
            setup_errs++;
        end
        // Rest of the line is free text
        n = $fgets(rest, fd);
    end
    $fclose(fd);
    if (n_prog == 0) begin
        $display("cpu16_input.dat holds no program words");
        setup_errs++;
    end
endtask

task automatic load_ram();
    for (int a = 0; a < 256; a++) begin
        if (a < n_prog) begin
            ram[a] = prog[a];
        end else begin
            ram[a] = {8'(a) ^ 8'h5a, 8'(a)};
        end
    end
endtask

task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n     = 1'b0;
    cen       = 1'b1;
    dmp_valid = 1'b0;
    load_ram();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
endtask

task automatic run_program(input logic random_cen);
    int cycles;
    int rnd;
    apply_reset();
    cycles = 0;
    while (!halted && cycles < 2000) begin
        @(posedge clk);
        #1;
        if (random_cen) begin
            rnd = $random(seed);
            cen = rnd[0];
        end
        cycles++;
    end
    cen = 1'b1;
    if (!halted) begin
        $display("core never halted within 2000 cycles (random cen %0d)", random_cen);
        timeouts++;
    end
endtask

task automatic dump_regs();
    for (int i = 0; i < reg_n; i++) begin
        @(posedge clk);
        #1;
        dmp_addr  = idx_w'(i);
        dmp_valid = 1'b1;
    end
    @(posedge clk);
    #1;
    dmp_valid = 1'b0;
    run_done  = 1'b1;
    @(posedge clk);
    #1;
    run_done = 1'b0;
endtask

task automatic report_and_finish();
    $display("errors: stores %0d, regs %0d, setup %0d, timeouts %0d",
             store_errs, reg_errs, setup_errs, timeouts);
    if (store_errs + reg_errs + setup_errs + timeouts == 0) begin
        $display("test passed");
    end else begin
        $display("test failed");
    end
    $finish;
endtask

initial begin
    rst_n     = 1'b0;
    cen       = 1'b1;
    ram_dout  = '0;
    dmp_addr  = '0;
    dmp_valid = 1'b0;
    run_done  = 1'b0;
    read_input();
    run_program(1'b0);
    if (timeouts == 0) begin
        dump_regs();
        run_program(1'b1);
    end
    if (timeouts == 0) begin
        dump_regs();
    end
    report_and_finish();
end

endmodule
